/* design/branch_target_unit.sv */
`timescale 1ns/1ps

module branch_target_unit (
    input  logic [mips_pkg::XLEN-1:0] i_pc,
    decode_if.sink                    i_dec,
    input  logic [mips_pkg::XLEN-1:0] i_rs_data,
    input  logic [mips_pkg::XLEN-1:0] i_rt_data,
    output logic                      o_pc_modify,
    output logic [mips_pkg::XLEN-1:0] o_target,
    output logic [mips_pkg::XLEN-1:0] o_link_addr
);
    import mips_pkg::*;

    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] branch_disp;
    logic            operands_equal;
    logic            is_branch;

    assign pc_plus4    = i_pc + XLEN'(4);
    assign o_link_addr = i_pc + XLEN'(8);               // Skips the delay slot

    // Sign-extended word offset
    assign branch_disp = {{(XLEN-IMM_W-2){i_dec.addr_offset[IMM_W-1]}},
                          i_dec.addr_offset[IMM_W-1:0], 2'b00};

    assign operands_equal = (i_rs_data == i_rt_data);
    assign is_branch      = (i_dec.addr_type == ADDR_REL);

    // Jumps always taken, branches only on a compare match
    assign o_pc_modify = i_dec.jump_or_branch &&
                         (!is_branch || (operands_equal == i_dec.cmp_equal));

    always_comb begin
        o_target = '0;
        if (i_dec.jump_or_branch) begin
            case (i_dec.addr_type)
                ADDR_REG: o_target = i_rs_data;         // addr_reg is always rs
                ADDR_ABS: o_target = {pc_plus4[XLEN-1:XLEN-4], i_dec.addr_offset, 2'b00};
                ADDR_REL: o_target = pc_plus4 + branch_disp;
                default:  o_target = '0;
            endcase
        end
    end

endmodule

/* design/decode_if.sv */
`timescale 1ns/1ps

interface decode_if;
    import mips_pkg::*;

    logic [FUNCT_W-1:0]    funct;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] sa;
    logic [IMM_W-1:0]      imm;
    logic [JOFF_W-1:0]     addr_offset;                 // Jump offset or branch offset
    logic                  jump_or_branch;
    logic                  link_ret;
    addr_type_t            addr_type;
    logic [REG_ADDR_W-1:0] link_reg;
    logic [REG_ADDR_W-1:0] addr_reg;
    logic                  cmp_equal;                   // Branch on equal when set
    logic                  immediate;
    logic                  mem_op;
    logic                  mem_store;                   // 0 load, 1 store
    mem_size_t             mem_size;
    logic                  unsigned_op;

    modport decoder (
        output funct, rs, rt, rd, sa, imm, addr_offset,
        output jump_or_branch, link_ret, addr_type, link_reg, addr_reg, cmp_equal,
        output immediate, mem_op, mem_store, mem_size, unsigned_op
    );

    modport sink (
        input funct, rs, rt, rd, sa, imm, addr_offset,
        input jump_or_branch, link_ret, addr_type, link_reg, addr_reg, cmp_equal,
        input immediate, mem_op, mem_store, mem_size, unsigned_op
    );

endinterface

/* design/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_instr_valid,
    input  logic [mips_pkg::XLEN-1:0]       i_instr,
    input  logic [mips_pkg::XLEN-1:0]       i_pc,
    input  logic                            i_wb_en,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_wb_reg,
    input  logic [mips_pkg::XLEN-1:0]       i_wb_data,
    output logic                            o_valid,
    output logic [mips_pkg::FUNCT_W-1:0]    o_funct,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_rs,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_rt,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_rd,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_sa,
    output logic [mips_pkg::IMM_W-1:0]      o_imm,
    output logic [mips_pkg::XLEN-1:0]       o_rs_data,
    output logic [mips_pkg::XLEN-1:0]       o_rt_data,
    output logic                            o_immediate,
    output logic                            o_mem_op,
    output logic                            o_mem_store,
    output logic [1:0]                      o_mem_size,
    output logic                            o_mem_unsigned,
    output logic                            o_link_en,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_link_reg,
    output logic [mips_pkg::XLEN-1:0]       o_link_addr,
    output logic                            o_pc_modify,
    output logic [mips_pkg::XLEN-1:0]       o_target
);
    import mips_pkg::*;

    decode_if        dec_bus ();
    logic [XLEN-1:0] rs_data;
    logic [XLEN-1:0] rt_data;
    logic            pc_modify;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] link_addr;
    id_ex_t          stage;

    instr_decoder u_decoder (
        .i_instr (i_instr),
        .o_dec   (dec_bus)
    );

    register_file u_regfile (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_wb_en   (i_wb_en),
        .i_wb_reg  (i_wb_reg),
        .i_wb_data (i_wb_data),
        .i_dec     (dec_bus),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    branch_target_unit u_target (
        .i_pc        (i_pc),
        .i_dec       (dec_bus),
        .i_rs_data   (rs_data),
        .i_rt_data   (rt_data),
        .o_pc_modify (pc_modify),
        .o_target    (target),
        .o_link_addr (link_addr)
    );

    id_ex_register u_id_ex (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_valid     (i_instr_valid),
        .i_dec       (dec_bus),
        .i_rs_data   (rs_data),
        .i_rt_data   (rt_data),
        .i_pc_modify (pc_modify),
        .i_target    (target),
        .i_link_addr (link_addr),
        .o_valid     (o_valid),
        .o_stage     (stage)
    );

    assign o_funct        = stage.funct;
    assign o_rs           = stage.rs;
    assign o_rt           = stage.rt;
    assign o_rd           = stage.rd;
    assign o_sa           = stage.sa;
    assign o_imm          = stage.imm;
    assign o_rs_data      = stage.rs_data;
    assign o_rt_data      = stage.rt_data;
    assign o_immediate    = stage.immediate;
    assign o_mem_op       = stage.mem_op;
    assign o_mem_store    = stage.mem_store;
    assign o_mem_size     = stage.mem_size;
    assign o_mem_unsigned = stage.mem_unsigned;
    assign o_link_en      = stage.link_en;
    assign o_link_reg     = stage.link_reg;
    assign o_link_addr    = stage.link_addr;
    assign o_pc_modify    = stage.pc_modify;
    assign o_target       = stage.target;

endmodule

/* design/id_ex_register.sv */
`timescale 1ns/1ps

module id_ex_register (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_valid,
    decode_if.sink                    i_dec,
    input  logic [mips_pkg::XLEN-1:0] i_rs_data,
    input  logic [mips_pkg::XLEN-1:0] i_rt_data,
    input  logic                      i_pc_modify,
    input  logic [mips_pkg::XLEN-1:0] i_target,
    input  logic [mips_pkg::XLEN-1:0] i_link_addr,
    output logic                      o_valid,
    output mips_pkg::id_ex_t          o_stage
);
    import mips_pkg::*;

    id_ex_t next_stage;

    always_comb begin
        next_stage.funct        = i_dec.funct;
        next_stage.rs           = i_dec.rs;
        next_stage.rt           = i_dec.rt;
        next_stage.rd           = i_dec.rd;
        next_stage.sa           = i_dec.sa;
        next_stage.imm          = i_dec.imm;
        next_stage.rs_data      = i_rs_data;
        next_stage.rt_data      = i_rt_data;
        next_stage.mem_op       = i_dec.mem_op;
        next_stage.mem_store    = i_dec.mem_store;
        next_stage.mem_size     = i_dec.mem_size;
        next_stage.mem_unsigned = i_dec.unsigned_op;
        next_stage.immediate    = i_dec.immediate;
        next_stage.link_en      = i_dec.link_ret;
        next_stage.link_reg     = i_dec.link_reg;
        next_stage.link_addr    = i_link_addr;
        next_stage.pc_modify    = i_pc_modify;
        next_stage.target       = i_target;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
            o_stage <= '0;
        end else begin
            o_valid <= i_valid;                         // One-cycle strobe
            if (i_valid)
                o_stage <= next_stage;                  // Holds until next instruction
        end
    end

endmodule

/* design/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
    input  logic [mips_pkg::XLEN-1:0] i_instr,
    decode_if.decoder                 o_dec
);
    import mips_pkg::*;

    logic [5:0]            opcode;
    logic [FUNCT_W-1:0]    funct_field;
    logic [REG_ADDR_W-1:0] rs_field;
    logic [REG_ADDR_W-1:0] rt_field;
    logic [REG_ADDR_W-1:0] rd_field;
    logic [REG_ADDR_W-1:0] sa_field;
    logic [IMM_W-1:0]      imm_field;

    assign opcode      = i_instr[31:26];
    assign rs_field    = i_instr[25:21];
    assign rt_field    = i_instr[20:16];
    assign rd_field    = i_instr[15:11];
    assign sa_field    = i_instr[10:6];
    assign imm_field   = i_instr[15:0];
    assign funct_field = i_instr[5:0];

    always_comb begin
        // Everything not named by an opcode stays zero
        o_dec.funct          = '0;
        o_dec.rs             = '0;
        o_dec.rt             = '0;
        o_dec.rd             = '0;
        o_dec.sa             = '0;
        o_dec.imm            = '0;
        o_dec.addr_offset    = '0;
        o_dec.jump_or_branch = 1'b0;
        o_dec.link_ret       = 1'b0;
        o_dec.addr_type      = ADDR_REG;
        o_dec.link_reg       = '0;
        o_dec.addr_reg       = '0;
        o_dec.cmp_equal      = 1'b0;
        o_dec.immediate      = 1'b0;
        o_dec.mem_op         = 1'b0;
        o_dec.mem_store      = 1'b0;
        o_dec.mem_size       = MEM_BYTE;
        o_dec.unsigned_op    = 1'b0;

        case (opcode)
            OP_SPECIAL: begin
                o_dec.rs = rs_field;
                case (funct_field)
                    FUNCT_JR: begin
                        o_dec.jump_or_branch = 1'b1;
                        o_dec.addr_reg       = rs_field;
                    end
                    FUNCT_JALR: begin
                        o_dec.rd             = rd_field;
                        o_dec.jump_or_branch = 1'b1;
                        o_dec.link_ret       = 1'b1;
                        o_dec.link_reg       = rd_field;   // Link goes to rd
                        o_dec.addr_reg       = rs_field;
                    end
                    default: begin                         // Plain R-type ALU ops
                        o_dec.funct = funct_field;
                        o_dec.rt    = rt_field;
                        o_dec.rd    = rd_field;
                        o_dec.sa    = sa_field;
                    end
                endcase
            end
            OP_J, OP_JAL: begin
                o_dec.addr_offset    = i_instr[JOFF_W-1:0];
                o_dec.jump_or_branch = 1'b1;
                o_dec.addr_type      = ADDR_ABS;
                if (opcode == OP_JAL) begin
                    o_dec.link_ret = 1'b1;
                    o_dec.link_reg = LINK_RA;
                end
            end
            OP_BEQ, OP_BNE: begin
                o_dec.rs             = rs_field;
                o_dec.rt             = rt_field;
                o_dec.addr_offset    = {{(JOFF_W-IMM_W){1'b0}}, imm_field};
                o_dec.jump_or_branch = 1'b1;
                o_dec.addr_type      = ADDR_REL;
                o_dec.cmp_equal      = (opcode == OP_BEQ);
                o_dec.immediate      = 1'b1;
            end
            default: begin
                case (opcode[5:3])
                    3'b001: begin                          // Immediate arithmetic
                        o_dec.funct     = {3'b000, opcode[2:0]};
                        o_dec.rs        = rs_field;
                        o_dec.rt        = rt_field;
                        o_dec.imm       = imm_field;
                        o_dec.immediate = 1'b1;
                    end
                    3'b100, 3'b101: begin                  // Loads and stores
                        o_dec.funct       = {3'b000, opcode[2:0]};
                        o_dec.rs          = rs_field;
                        o_dec.rt          = rt_field;
                        o_dec.imm         = imm_field;     // Base offset for execute
                        o_dec.immediate   = 1'b1;
                        o_dec.mem_op      = 1'b1;
                        o_dec.mem_store   = opcode[3];
                        o_dec.mem_size    = mem_size_t'(opcode[1:0]);
                        o_dec.unsigned_op = ~opcode[3] & opcode[2];
                    end
                    default: begin
                    end
                endcase
            end
        endcase
    end

endmodule

/* design/mips_pkg.sv */
package mips_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int FUNCT_W    = 6;
    localparam int IMM_W      = 16;
    localparam int JOFF_W     = 26;                     // J and JAL offset field

    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;

    localparam logic [5:0] FUNCT_JR   = 6'b001000;
    localparam logic [5:0] FUNCT_JALR = 6'b001001;

    localparam logic [REG_ADDR_W-1:0] LINK_RA = 5'd31; // Return address register

    typedef enum logic [1:0] {
        ADDR_REG = 2'b00,                               // Target held in a register
        ADDR_ABS = 2'b01,                               // Upper PC bits with 26-bit offset
        ADDR_REL = 2'b10                                // PC + 4 + shifted 16-bit offset
    } addr_type_t;

    // Encoded as the low two bits of the load/store opcode
    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b11
    } mem_size_t;

    typedef struct packed {
        logic [FUNCT_W-1:0]    funct;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] sa;
        logic [IMM_W-1:0]      imm;
        logic [XLEN-1:0]       rs_data;
        logic [XLEN-1:0]       rt_data;
        logic                  mem_op;
        logic                  mem_store;
        mem_size_t             mem_size;
        logic                  mem_unsigned;
        logic                  immediate;
        logic                  link_en;
        logic [REG_ADDR_W-1:0] link_reg;
        logic [XLEN-1:0]       link_addr;
        logic                  pc_modify;
        logic [XLEN-1:0]       target;
    } id_ex_t;

endpackage

/* design/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_wb_en,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_wb_reg,
    input  logic [mips_pkg::XLEN-1:0]       i_wb_data,
    decode_if.sink                          i_dec,
    output logic [mips_pkg::XLEN-1:0]       o_rs_data,
    output logic [mips_pkg::XLEN-1:0]       o_rt_data
);
    import mips_pkg::*;

    logic [XLEN-1:0] regs [1:31];                       // Register 0 has no storage
    logic            wb_live;

    assign wb_live = i_wb_en && (i_wb_reg != '0);

    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0)
            return '0;
        else if (wb_live && (i_wb_reg == addr))
            return i_wb_data;                           // Same-cycle write bypass
        else
            return regs[addr];
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (wb_live) begin
            regs[i_wb_reg] <= i_wb_data;
        end
    end

    always_comb begin
        o_rs_data = read_port(i_dec.rs);
        o_rt_data = read_port(i_dec.rt);
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the decode stage testbench with Verilator, runs it and checks the log

BUILD_DIR=obj_dir
LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module tb_decode_stage --Mdir "$BUILD_DIR" -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_decode_stage" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* sim/decode_model.svh */
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

logic [31:0] shadow_regs [0:31];                        // Register values as the model sees them

task automatic clear_shadow();
    for (int i = 0; i < 32; i++)
        shadow_regs[i] = 32'd0;
endtask

task automatic write_shadow(input logic wb_en, input logic [4:0] wb_reg,
                            input logic [31:0] wb_data);
    if (wb_en && wb_reg != 5'd0)
        shadow_regs[wb_reg] = wb_data;                  // Register 0 stays zero
endtask

function automatic logic [31:0] read_shadow(input logic [4:0] addr, input logic wb_en,
                                            input logic [4:0] wb_reg, input logic [31:0] wb_data);
    if (addr == 5'd0)
        return 32'd0;
    if (wb_en && wb_reg == addr)
        return wb_data;                                 // Same-cycle write is seen by the read
    return shadow_regs[addr];
endfunction

function automatic logic [31:0] branch_target(input logic [31:0] instr, input logic [31:0] pc,
                                              input logic [31:0] rs_val);
    logic [31:0] pc4;
    logic [5:0]  op;
    pc4 = pc + 32'd4;
    op  = instr[31:26];
    if (op == OP_J || op == OP_JAL)
        return {pc4[31:28], instr[25:0], 2'b00};
    if (op == OP_BEQ || op == OP_BNE)
        return pc4 + {{14{instr[15]}}, instr[15:0], 2'b00};
    if (op == OP_SPECIAL && (instr[5:0] == FUNCT_JR || instr[5:0] == FUNCT_JALR))
        return rs_val;
    return 32'd0;
endfunction

function automatic id_ex_t decode_expected(input logic [31:0] instr, input logic [31:0] pc,
                                           input logic wb_en, input logic [4:0] wb_reg,
                                           input logic [31:0] wb_data);
    id_ex_t     e;
    logic [5:0] op;
    logic [5:0] fn;
    logic       is_branch;
    e         = '0;
    op        = instr[31:26];
    fn        = instr[5:0];
    is_branch = (op == OP_BEQ || op == OP_BNE);
    e.link_addr = pc + 32'd8;                           // Link skips the delay slot
    if (op == OP_SPECIAL) begin
        e.rs = instr[25:21];
        if (fn == FUNCT_JR || fn == FUNCT_JALR) begin
            e.pc_modify = 1'b1;
            if (fn == FUNCT_JALR) begin
                e.rd       = instr[15:11];
                e.link_en  = 1'b1;
                e.link_reg = instr[15:11];
            end
        end else begin
            e.funct = fn;
            e.rt    = instr[20:16];
            e.rd    = instr[15:11];
            e.sa    = instr[10:6];
        end
    end else if (op == OP_J || op == OP_JAL) begin
        e.pc_modify = 1'b1;
        if (op == OP_JAL) begin
            e.link_en  = 1'b1;
            e.link_reg = 5'd31;
        end
    end else if (is_branch) begin
        e.rs        = instr[25:21];
        e.rt        = instr[20:16];
        e.immediate = 1'b1;
    end else if (op[5:3] == 3'b001 || op[5:4] == 2'b10) begin
        e.funct     = {3'b000, op[2:0]};
        e.rs        = instr[25:21];
        e.rt        = instr[20:16];
        e.imm       = instr[15:0];
        e.immediate = 1'b1;
        if (op[5:4] == 2'b10) begin                     // Loads and stores
            e.mem_op       = 1'b1;
            e.mem_store    = op[3];
            e.mem_size     = mem_size_t'(op[1:0]);
            e.mem_unsigned = !op[3] && op[2];
        end
    end
    e.rs_data = read_shadow(e.rs, wb_en, wb_reg, wb_data);
    e.rt_data = read_shadow(e.rt, wb_en, wb_reg, wb_data);
    if (is_branch)
        e.pc_modify = ((e.rs_data == e.rt_data) == (op == OP_BEQ));
    e.target = branch_target(instr, pc, e.rs_data);
    return e;
endfunction

`endif

/* sim/tb_decode_stage.sv */
`timescale 1ns/1ps

module tb_decode_stage;
    import mips_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int TEST_LEN     = 400;
    localparam int NUM_TESTS    = 6;
    localparam int TOTAL_CYCLES = RESET_CYCLES + NUM_TESTS * (TEST_LEN + 1) + 2;

    localparam logic [5:0] UNUSED_OPS [4] = '{6'h06, 6'h10, 6'h1c, 6'h3f};

    logic        i_clk;
    logic        i_reset;
    logic        i_instr_valid;
    logic [31:0] i_instr;
    logic [31:0] i_pc;
    logic        i_wb_en;
    logic [4:0]  i_wb_reg;
    logic [31:0] i_wb_data;
    logic        o_valid;
    logic [5:0]  o_funct;
    logic [4:0]  o_rs;
    logic [4:0]  o_rt;
    logic [4:0]  o_rd;
    logic [4:0]  o_sa;
    logic [15:0] o_imm;
    logic [31:0] o_rs_data;
    logic [31:0] o_rt_data;
    logic        o_immediate;
    logic        o_mem_op;
    logic        o_mem_store;
    logic [1:0]  o_mem_size;
    logic        o_mem_unsigned;
    logic        o_link_en;
    logic [4:0]  o_link_reg;
    logic [31:0] o_link_addr;
    logic        o_pc_modify;
    logic [31:0] o_target;

    int     error_count;
    int     check_count;
    logic   exp_valid_q [$];                            // One entry per driven cycle
    id_ex_t exp_stage_q [$];                            // One entry per strobe
    id_ex_t held_exp;                                   // Outputs hold between strobes

    `include "decode_model.svh"

    decode_stage u_dut (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_instr_valid  (i_instr_valid),
        .i_instr        (i_instr),
        .i_pc           (i_pc),
        .i_wb_en        (i_wb_en),
        .i_wb_reg       (i_wb_reg),
        .i_wb_data      (i_wb_data),
        .o_valid        (o_valid),
        .o_funct        (o_funct),
        .o_rs           (o_rs),
        .o_rt           (o_rt),
        .o_rd           (o_rd),
        .o_sa           (o_sa),
        .o_imm          (o_imm),
        .o_rs_data      (o_rs_data),
        .o_rt_data      (o_rt_data),
        .o_immediate    (o_immediate),
        .o_mem_op       (o_mem_op),
        .o_mem_store    (o_mem_store),
        .o_mem_size     (o_mem_size),
        .o_mem_unsigned (o_mem_unsigned),
        .o_link_en      (o_link_en),
        .o_link_reg     (o_link_reg),
        .o_link_addr    (o_link_addr),
        .o_pc_modify    (o_pc_modify),
        .o_target       (o_target)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic verify_outputs();
        logic exp_valid;
        exp_valid = 1'b0;
        if (exp_valid_q.size() > 0)
            exp_valid = exp_valid_q.pop_front();
        if (exp_valid) begin
            held_exp = exp_stage_q.pop_front();
            check_count++;
        end
        compare_field("o_valid", 32'(o_valid), 32'(exp_valid));
        compare_field("o_funct", 32'(o_funct), 32'(held_exp.funct));
        compare_field("o_rs", 32'(o_rs), 32'(held_exp.rs));
        compare_field("o_rt", 32'(o_rt), 32'(held_exp.rt));
        compare_field("o_rd", 32'(o_rd), 32'(held_exp.rd));
        compare_field("o_sa", 32'(o_sa), 32'(held_exp.sa));
        compare_field("o_imm", 32'(o_imm), 32'(held_exp.imm));
        compare_field("o_rs_data", o_rs_data, held_exp.rs_data);
        compare_field("o_rt_data", o_rt_data, held_exp.rt_data);
        compare_field("o_immediate", 32'(o_immediate), 32'(held_exp.immediate));
        compare_field("o_mem_op", 32'(o_mem_op), 32'(held_exp.mem_op));
        compare_field("o_mem_store", 32'(o_mem_store), 32'(held_exp.mem_store));
        compare_field("o_mem_size", 32'(o_mem_size), 32'(held_exp.mem_size));
        compare_field("o_mem_unsigned", 32'(o_mem_unsigned), 32'(held_exp.mem_unsigned));
        compare_field("o_link_en", 32'(o_link_en), 32'(held_exp.link_en));
        compare_field("o_link_reg", 32'(o_link_reg), 32'(held_exp.link_reg));
        compare_field("o_link_addr", o_link_addr, held_exp.link_addr);
        compare_field("o_pc_modify", 32'(o_pc_modify), 32'(held_exp.pc_modify));
        compare_field("o_target", o_target, held_exp.target);
    endtask

    // Kind 1 ALU and unused, 2 memory, 3 jumps, 4 branches, 0 any of them
    function automatic logic [31:0] random_instr(input int mode);
        logic [31:0] instr;
        int          kind;
        instr = $urandom;
        kind  = mode;
        if (kind == 0)
            kind = int'($urandom_range(4, 1));
        case (kind)
            1: begin
                case ($urandom_range(2, 0))
                    0: instr[31:26] = OP_SPECIAL;
                    1: instr[31:26] = {3'b001, 3'($urandom)};
                    default: instr[31:26] = UNUSED_OPS[2'($urandom)];
                endcase
            end
            2: instr[31:26] = {2'b10, 4'($urandom)};
            3: begin
                instr[31:26] = ($urandom_range(1, 0) == 0) ? OP_J : OP_JAL;
                if ($urandom_range(1, 0) == 0) begin
                    instr[31:26] = OP_SPECIAL;
                    instr[5:0]   = ($urandom_range(1, 0) == 0) ? FUNCT_JR : FUNCT_JALR;
                end
            end
            default: begin
                instr[31:26] = ($urandom_range(1, 0) == 0) ? OP_BEQ : OP_BNE;
                if ($urandom_range(1, 0) == 0)
                    instr[20:16] = instr[25:21];        // Same register so the compare matches
            end
        endcase
        return instr;
    endfunction

    task automatic apply_cycle(input int mode, input logic strobe);
        logic [31:0] instr;
        logic [31:0] pc;
        logic        wb_en;
        logic [4:0]  wb_reg;
        logic [31:0] wb_data;
        instr   = random_instr(mode == 5 ? 0 : mode);
        pc      = $urandom & 32'hffff_fffc;
        wb_en   = 1'($urandom);
        wb_reg  = 5'($urandom);
        wb_data = $urandom;
        if (mode == 5) begin
            wb_en = 1'b1;
            case ($urandom_range(3, 0))
                0: wb_reg = instr[25:21];               // Bypass into rs
                1: wb_reg = instr[20:16];               // Bypass into rt
                2: wb_reg = 5'd0;
                default: ;
            endcase
        end
        i_instr_valid = strobe;
        i_instr       = instr;
        i_pc          = pc;
        i_wb_en       = wb_en;
        i_wb_reg      = wb_reg;
        i_wb_data     = wb_data;
        exp_valid_q.push_back(strobe);
        if (strobe)
            exp_stage_q.push_back(decode_expected(instr, pc, wb_en, wb_reg, wb_data));
        write_shadow(wb_en, wb_reg, wb_data);
    endtask

    task automatic idle_cycle();
        i_instr_valid = 1'b0;
        i_wb_en       = 1'b0;
        exp_valid_q.push_back(1'b0);
    endtask

    task automatic run_test(input string name, input int mode, input int strobe_pct);
        int errors_before;
        errors_before = error_count;
        repeat (TEST_LEN) begin
            @(negedge i_clk);
            verify_outputs();
            apply_cycle(mode, $urandom_range(99, 0) < strobe_pct);
        end
        @(negedge i_clk);
        verify_outputs();
        idle_cycle();
        $display("test %s: %0d cycles, %0d mismatches", name, TEST_LEN,
                 error_count - errors_before);
    endtask

    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD * 2);
        $display("Timeout: run did not finish within %0d ns", TOTAL_CYCLES * CLK_PERIOD * 2);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        void'($urandom(32'hf206));
        i_clk         = 1'b0;
        i_reset       = 1'b1;
        i_instr_valid = 1'b0;
        i_instr       = 32'd0;
        i_pc          = 32'd0;
        i_wb_en       = 1'b0;
        i_wb_reg      = 5'd0;
        i_wb_data     = 32'd0;
        error_count   = 0;
        check_count   = 0;
        held_exp      = '0;
        clear_shadow();

        repeat (RESET_CYCLES) begin
            @(negedge i_clk);
            verify_outputs();                           // Expect cleared outputs in reset
        end
        i_reset = 1'b0;
        $display("test reset: %0d cycles, %0d mismatches", RESET_CYCLES, error_count);

        run_test("strobe_timing", 0, 50);
        run_test("alu_decode", 1, 80);
        run_test("load_store", 2, 80);
        run_test("jumps", 3, 80);
        run_test("branches", 4, 80);
        run_test("write_back", 5, 100);
        @(negedge i_clk);
        verify_outputs();

        $display("summary: %0d instructions checked, %0d mismatches", check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+sim
design/mips_pkg.sv
design/decode_if.sv
design/instr_decoder.sv
design/register_file.sv
design/branch_target_unit.sv
design/id_ex_register.sv
design/decode_stage.sv
sim/tb_decode_stage.sv
